// ==== verilog/im2col_pkg.sv ====
/*
 * Shared widths, register map, DMA channel offsets, loader states and the
 * descriptor type of the im2col peripheral controller. Imported by every RTL module.
 */
package im2col_pkg;

  localparam int unsigned REG_AW = 8;
  localparam int unsigned REG_DW = 32;
  localparam int unsigned DMA_AW = 32;
  localparam int unsigned DMA_DW = 32;

  localparam logic [DMA_AW-1:0] DMA_BASE    = 32'h0003_0000; // channel 0 window.
  localparam logic [DMA_AW-1:0] DMA_CH_SIZE = 32'h0000_0100;

  // byte offsets inside one channel window.
  localparam logic [7:0] DIM        = 8'h00;
  localparam logic [7:0] SLOT       = 8'h04;
  localparam logic [7:0] SRC_TYPE   = 8'h08;
  localparam logic [7:0] DST_TYPE   = 8'h0c;
  localparam logic [7:0] PAD_TOP    = 8'h10;
  localparam logic [7:0] PAD_BOTTOM = 8'h14;
  localparam logic [7:0] PAD_LEFT   = 8'h18;
  localparam logic [7:0] PAD_RIGHT  = 8'h1c;
  localparam logic [7:0] SRC_PTR    = 8'h20;
  localparam logic [7:0] DST_PTR    = 8'h24;
  localparam logic [7:0] SRC_INC_D1 = 8'h28;
  localparam logic [7:0] SRC_INC_D2 = 8'h2c;
  localparam logic [7:0] DST_INC_D1 = 8'h30;
  localparam logic [7:0] DST_INC_D2 = 8'h34;
  localparam logic [7:0] SIZE_D2    = 8'h38;
  localparam logic [7:0] SIZE_D1    = 8'h3c;

  // software register map.
  localparam logic [REG_AW-1:0] REG_START        = 8'h00;
  localparam logic [REG_AW-1:0] REG_END          = 8'h04;
  localparam logic [REG_AW-1:0] REG_CFG          = 8'h08; // {tx_slot, rx_slot, log_stride, dtype}.
  localparam logic [REG_AW-1:0] REG_CH_MASK      = 8'h0c;
  localparam logic [REG_AW-1:0] REG_INT_EN       = 8'h10;
  localparam logic [REG_AW-1:0] REG_STATUS       = 8'h14; // {fifo_empty, overflow, ready}.
  localparam logic [REG_AW-1:0] REG_IFR          = 8'h18;
  localparam logic [REG_AW-1:0] REG_DESC_PAD     = 8'h1c; // {top, bottom, left, right}.
  localparam logic [REG_AW-1:0] REG_DESC_IN_PTR  = 8'h20;
  localparam logic [REG_AW-1:0] REG_DESC_OUT_PTR = 8'h24;
  localparam logic [REG_AW-1:0] REG_DESC_INC     = 8'h28;
  localparam logic [REG_AW-1:0] REG_DESC_SIZE    = 8'h2c; // {size_d2, size_d1}.
  localparam logic [REG_AW-1:0] REG_DESC_PUSH    = 8'h30;

  typedef struct packed {
    logic [7:0]  pad_top;
    logic [7:0]  pad_bottom;
    logic [7:0]  pad_left;
    logic [7:0]  pad_right;
    logic [31:0] in_ptr;
    logic [31:0] out_ptr;
    logic [22:0] in_inc_d2; // in elements.
    logic [15:0] size_d2;
    logic [15:0] size_d1;
  } desc_t;

  // write states follow the channel offset order, so the loader steps by one.
  typedef enum logic [4:0] {
    LD_IDLE, LD_DIM, LD_SLOT, LD_SRC_TYPE, LD_DST_TYPE,
    LD_PAD_TOP, LD_PAD_BOTTOM, LD_PAD_LEFT, LD_PAD_RIGHT,
    LD_SRC_PTR, LD_DST_PTR, LD_SRC_INC_D1, LD_SRC_INC_D2,
    LD_DST_INC_D1, LD_DST_INC_D2, LD_SIZE_D2, LD_SIZE_D1, LD_DONE
  } load_state_e;

endpackage

// ==== verilog/im2col_spc_regs.sv ====
/*
 * Software register block. Holds the configuration, stages descriptor fields,
 * pushes them into the FIFO and forms the done pulse, status and interrupt flag.
 */
module im2col_spc_regs import im2col_pkg::*; #(
  parameter int unsigned NUM_CH = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              reg_we_i,
  input  logic              reg_re_i,
  input  logic [REG_AW-1:0] reg_addr_i,
  input  logic [REG_DW-1:0] reg_wdata_i,
  output logic [REG_DW-1:0] reg_rdata_o,
  input  logic              fifo_full_i,
  input  logic              fifo_empty_i,
  input  logic              loader_idle_i,
  input  logic              all_idle_i,
  output logic              push_o,
  output desc_t             desc_o,
  output logic              start_o,
  output logic [1:0]        data_type_o,
  output logic [3:0]        log_stride_o,
  output logic [7:0]        rx_slot_o,
  output logic [7:0]        tx_slot_o,
  output logic [NUM_CH-1:0] ch_mask_o,
  output logic              intr_o
);

  logic  end_q, busy_q, ovf_q, ifr_q, int_en_q;
  logic  push_req, ifr_rd, done;
  desc_t stage_q;

  assign start_o  = reg_we_i && (reg_addr_i == REG_START);
  assign push_req = reg_we_i && (reg_addr_i == REG_DESC_PUSH);
  assign push_o   = push_req && !fifo_full_i; // a push into a full FIFO is dropped.
  assign ifr_rd   = reg_re_i && (reg_addr_i == REG_IFR);
  assign desc_o   = stage_q;
  assign intr_o   = ifr_q;

  // everything drained after the end flag.
  assign done = end_q && fifo_empty_i && loader_idle_i && all_idle_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      end_q        <= 1'b0;
      busy_q       <= 1'b0;
      ovf_q        <= 1'b0;
      ifr_q        <= 1'b0;
      int_en_q     <= 1'b0;
      data_type_o  <= '0;
      log_stride_o <= '0;
      rx_slot_o    <= '0;
      tx_slot_o    <= '0;
      ch_mask_o    <= '0;
    end else begin
      if (done) begin
        end_q  <= 1'b0;
        busy_q <= 1'b0; // back to ready.
      end else begin
        if (reg_we_i && reg_addr_i == REG_END) end_q <= 1'b1;
        if (start_o) busy_q <= 1'b1;
      end
      if (start_o) ovf_q <= 1'b0;
      else if (push_req && fifo_full_i) ovf_q <= 1'b1;
      if (done && int_en_q) ifr_q <= 1'b1;
      else if (ifr_rd) ifr_q <= 1'b0;
      if (reg_we_i && reg_addr_i == REG_INT_EN) int_en_q <= reg_wdata_i[0];
      if (reg_we_i && reg_addr_i == REG_CH_MASK) ch_mask_o <= reg_wdata_i[NUM_CH-1:0];
      if (reg_we_i && reg_addr_i == REG_CFG) begin
        data_type_o  <= reg_wdata_i[1:0];
        log_stride_o <= reg_wdata_i[5:2];
        rx_slot_o    <= reg_wdata_i[13:6];
        tx_slot_o    <= reg_wdata_i[21:14];
      end
    end
  end

  // descriptor staging.
  always_ff @(posedge clk_i) begin
    if (reg_we_i) begin
      case (reg_addr_i)
        REG_DESC_PAD: begin
          stage_q.pad_top    <= reg_wdata_i[31:24];
          stage_q.pad_bottom <= reg_wdata_i[23:16];
          stage_q.pad_left   <= reg_wdata_i[15:8];
          stage_q.pad_right  <= reg_wdata_i[7:0];
        end
        REG_DESC_IN_PTR:  stage_q.in_ptr    <= reg_wdata_i;
        REG_DESC_OUT_PTR: stage_q.out_ptr   <= reg_wdata_i;
        REG_DESC_INC:     stage_q.in_inc_d2 <= reg_wdata_i[22:0];
        REG_DESC_SIZE: begin
          stage_q.size_d2 <= reg_wdata_i[31:16];
          stage_q.size_d1 <= reg_wdata_i[15:0];
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    if (reg_re_i) begin
      case (reg_addr_i)
        REG_END:     reg_rdata_o = {31'h0, end_q};
        REG_CFG:     reg_rdata_o = {10'h0, tx_slot_o, rx_slot_o, log_stride_o, data_type_o};
        REG_CH_MASK: reg_rdata_o = {{(REG_DW-NUM_CH){1'b0}}, ch_mask_o};
        REG_INT_EN:  reg_rdata_o = {31'h0, int_en_q};
        REG_STATUS:  reg_rdata_o = {29'h0, fifo_empty_i, ovf_q, !busy_q};
        REG_IFR:     reg_rdata_o = {31'h0, ifr_q};
        default:     reg_rdata_o = '0;
      endcase
    end
  end

  // an accepted push always leaves a descriptor in the FIFO.
  a_push_lands: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_o |=> !fifo_empty_i);

endmodule

// ==== verilog/im2col_desc_fifo.sv ====
/*
 * Fall-through descriptor FIFO. The head entry is visible on desc_o while the
 * FIFO is not empty, and a pop moves to the next one.
 */
module im2col_desc_fifo import im2col_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  desc_t desc_i,
  input  logic  pop_i,
  output desc_t desc_o,
  output logic  full_o,
  output logic  empty_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  desc_t            mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] usage_q;
  logic             do_push, do_pop;

  assign full_o  = (usage_q == CNT_W'(FIFO_DEPTH));
  assign empty_o = (usage_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign desc_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (do_push && !do_pop) usage_q <= usage_q + 1'b1;
      else if (do_pop && !do_push) usage_q <= usage_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= desc_i;
  end

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni) !(pop_i && empty_o));
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_o));

endmodule

// ==== verilog/im2col_ch_tracker.sv ====
/*
 * DMA channel tracker. Keeps a busy bit and a programmed bit per channel and
 * offers the lowest enabled channel that is not busy.
 */
module im2col_ch_tracker #(
  parameter int unsigned NUM_CH = 4,
  localparam int unsigned CHW   = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  logic              claim_i,
  input  logic [NUM_CH-1:0] ch_mask_i,
  input  logic [NUM_CH-1:0] dma_done_i,
  output logic [CHW-1:0]    free_ch_o,
  output logic              first_write_o,
  output logic              ch_full_o,
  output logic              all_idle_o
);

  logic [NUM_CH-1:0] busy_q;
  logic [NUM_CH-1:0] first_q; // set once the static registers of a channel are written.
  logic [NUM_CH-1:0] avail;

  assign avail = ch_mask_i & ~busy_q;

  // scanning downwards leaves the lowest available channel.
  always_comb begin
    free_ch_o = '0;
    for (int i = NUM_CH - 1; i >= 0; i--) begin
      if (avail[i]) free_ch_o = CHW'(i);
    end
  end

  assign ch_full_o     = (avail == '0);
  assign first_write_o = first_q[free_ch_o];
  assign all_idle_o    = (busy_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= '0;
      first_q <= '0;
    end else if (start_i) begin
      busy_q  <= '0;
      first_q <= '0;
    end else begin
      busy_q <= busy_q & ~dma_done_i;
      if (claim_i) begin
        busy_q[free_ch_o]  <= 1'b1;
        first_q[free_ch_o] <= 1'b1;
      end
    end
  end

  a_no_claim_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(claim_i && ch_full_o));

endmodule

// ==== verilog/im2col_dma_loader.sv ====
/*
 * DMA loader FSM. Claims a free channel for the FIFO head and programs it with a
 * fixed sequence of register writes, skipping the static ones on later uses.
 */
module im2col_dma_loader import im2col_pkg::*; #(
  parameter int unsigned NUM_CH = 4,
  localparam int unsigned CHW   = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  desc_t             desc_i,
  input  logic              fifo_empty_i,
  output logic              pop_o,
  input  logic [CHW-1:0]    free_ch_i,
  input  logic              first_write_i,
  input  logic              ch_full_i,
  output logic              claim_o,
  input  logic [1:0]        data_type_i,
  input  logic [3:0]        log_stride_i,
  input  logic [7:0]        rx_slot_i,
  input  logic [7:0]        tx_slot_i,
  output logic              dma_wr_o,
  output logic [DMA_AW-1:0] dma_addr_o,
  output logic [DMA_DW-1:0] dma_wdata_o,
  input  logic              dma_ack_i,
  output logic              idle_o
);

  load_state_e    state_q, state_d;
  logic [CHW-1:0] ch_q;
  logic           gap_q; // one idle cycle after each acked write.
  logic [7:0]     offset;
  logic [1:0]     shamt;
  logic           in_write;

  assign idle_o   = (state_q == LD_IDLE);
  assign pop_o    = (state_q == LD_DONE);
  assign claim_o  = idle_o && !fifo_empty_i && !ch_full_i;
  assign in_write = !idle_o && !pop_o;
  assign dma_wr_o = in_write && !gap_q;
  assign shamt    = 2'd2 - data_type_i; // bytes per element as a shift.

  always_comb begin
    state_d = state_q;
    case (state_q)
      LD_IDLE: if (claim_o) state_d = first_write_i ? LD_PAD_TOP : LD_DIM;
      LD_DONE: state_d = LD_IDLE;
      default: if (dma_wr_o && dma_ack_i) state_d = load_state_e'(state_q + 5'd1);
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LD_IDLE;
      ch_q    <= '0;
      gap_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      gap_q   <= dma_wr_o && dma_ack_i;
      if (claim_o) ch_q <= free_ch_i; // channel held for the whole sequence.
    end
  end

  always_comb begin
    offset      = DIM;
    dma_wdata_o = '0;
    case (state_q)
      LD_DIM:        dma_wdata_o = 32'd1;
      LD_SLOT:       begin offset = SLOT;       dma_wdata_o = {16'h0, tx_slot_i, rx_slot_i}; end
      LD_SRC_TYPE:   begin offset = SRC_TYPE;   dma_wdata_o = {30'h0, data_type_i}; end
      LD_DST_TYPE:   begin offset = DST_TYPE;   dma_wdata_o = {30'h0, data_type_i}; end
      LD_PAD_TOP:    begin offset = PAD_TOP;    dma_wdata_o = {24'h0, desc_i.pad_top}; end
      LD_PAD_BOTTOM: begin offset = PAD_BOTTOM; dma_wdata_o = {24'h0, desc_i.pad_bottom}; end
      LD_PAD_LEFT:   begin offset = PAD_LEFT;   dma_wdata_o = {24'h0, desc_i.pad_left}; end
      LD_PAD_RIGHT:  begin offset = PAD_RIGHT;  dma_wdata_o = {24'h0, desc_i.pad_right}; end
      LD_SRC_PTR:    begin offset = SRC_PTR;    dma_wdata_o = desc_i.in_ptr; end
      LD_DST_PTR:    begin offset = DST_PTR;    dma_wdata_o = desc_i.out_ptr; end
      LD_SRC_INC_D1: begin
        offset      = SRC_INC_D1;
        dma_wdata_o = ((32'd1 << log_stride_i) << shamt) & 32'h0000_003f;
      end
      LD_SRC_INC_D2: begin
        offset      = SRC_INC_D2;
        dma_wdata_o = ({9'h0, desc_i.in_inc_d2} << shamt) & 32'h007f_ffff;
      end
      LD_DST_INC_D1: begin offset = DST_INC_D1; dma_wdata_o = 32'd4 >> data_type_i; end
      LD_DST_INC_D2: begin offset = DST_INC_D2; dma_wdata_o = 32'd4 >> data_type_i; end
      LD_SIZE_D2:    begin offset = SIZE_D2;    dma_wdata_o = {16'h0, desc_i.size_d2}; end
      LD_SIZE_D1:    begin offset = SIZE_D1;    dma_wdata_o = {16'h0, desc_i.size_d1}; end
      default: ;
    endcase
  end

  assign dma_addr_o = DMA_BASE + DMA_AW'(ch_q) * DMA_CH_SIZE + DMA_AW'(offset);

  // the request is a level, held with its address and data until acked.
  a_wr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dma_wr_o && !dma_ack_i |=> dma_wr_o && $stable(dma_addr_o) && $stable(dma_wdata_o));

endmodule

// ==== verilog/im2col_spc_top.sv ====
/*
 * Top level of the im2col peripheral controller. Software stages descriptors on
 * the register port and the loader programs free DMA channels through the write port.
 */
module im2col_spc_top import im2col_pkg::*; #(
  parameter int unsigned NUM_CH     = 4,
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              reg_we_i,
  input  logic              reg_re_i,
  input  logic [REG_AW-1:0] reg_addr_i,
  input  logic [REG_DW-1:0] reg_wdata_i,
  output logic [REG_DW-1:0] reg_rdata_o,
  output logic              dma_wr_o,
  output logic [DMA_AW-1:0] dma_addr_o,
  output logic [DMA_DW-1:0] dma_wdata_o,
  input  logic              dma_ack_i,
  input  logic [NUM_CH-1:0] dma_done_i,
  output logic              intr_o
);

  localparam int unsigned CHW = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

  logic            fifo_push, fifo_pop, fifo_full, fifo_empty;
  desc_t           push_desc, head_desc;
  logic            start, all_idle, loader_idle, claim, ch_full, first_write;
  logic [CHW-1:0]  free_ch;
  logic [NUM_CH-1:0] ch_mask;
  logic [1:0]      data_type;
  logic [3:0]      log_stride;
  logic [7:0]      rx_slot, tx_slot;

  im2col_spc_regs #(.NUM_CH(NUM_CH)) i_regs (
    .clk_i, .rst_ni, .reg_we_i, .reg_re_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
    .fifo_full_i(fifo_full), .fifo_empty_i(fifo_empty),
    .loader_idle_i(loader_idle), .all_idle_i(all_idle),
    .push_o(fifo_push), .desc_o(push_desc), .start_o(start),
    .data_type_o(data_type), .log_stride_o(log_stride),
    .rx_slot_o(rx_slot), .tx_slot_o(tx_slot), .ch_mask_o(ch_mask), .intr_o
  );

  im2col_desc_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
    .clk_i, .rst_ni, .push_i(fifo_push), .desc_i(push_desc), .pop_i(fifo_pop),
    .desc_o(head_desc), .full_o(fifo_full), .empty_o(fifo_empty)
  );

  im2col_ch_tracker #(.NUM_CH(NUM_CH)) i_tracker (
    .clk_i, .rst_ni, .start_i(start), .claim_i(claim), .ch_mask_i(ch_mask), .dma_done_i,
    .free_ch_o(free_ch), .first_write_o(first_write), .ch_full_o(ch_full),
    .all_idle_o(all_idle)
  );

  im2col_dma_loader #(.NUM_CH(NUM_CH)) i_loader (
    .clk_i, .rst_ni, .desc_i(head_desc), .fifo_empty_i(fifo_empty), .pop_o(fifo_pop),
    .free_ch_i(free_ch), .first_write_i(first_write), .ch_full_i(ch_full), .claim_o(claim),
    .data_type_i(data_type), .log_stride_i(log_stride),
    .rx_slot_i(rx_slot), .tx_slot_i(tx_slot),
    .dma_wr_o, .dma_addr_o, .dma_wdata_o, .dma_ack_i, .idle_o(loader_idle)
  );

endmodule

// ==== dv/im2col_dma_model.sv ====
/*
 * DMA responder for the im2col testbench. Acks each channel register write after
 * a given delay, checks it against the expected write and pulses channel done.
 */
module im2col_dma_model #(
  parameter int unsigned NUM_CH = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              dma_wr_i,
  input  logic [31:0]       dma_addr_i,
  input  logic [31:0]       dma_wdata_i,
  output logic              dma_ack_o,
  output logic [NUM_CH-1:0] dma_done_o,
  input  logic [1:0]        ack_delay_i,
  input  logic              exp_valid_i,
  input  logic [31:0]       exp_addr_i,
  input  logic [31:0]       exp_data_i,
  input  logic [8*16-1:0]   test_name_i,
  output int                err_count_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int wait_cnt;

  initial begin
    dma_ack_o   = 1'b0;
    dma_done_o  = '0;
    err_count_o = 0;
    wait_cnt    = 0;
    forever begin
      @(posedge clk_i);
      #2;
      dma_ack_o = 1'b0; // a request is low for a cycle after each ack.
      if (dma_wr_i && rst_ni) begin
        if (wait_cnt >= int'(ack_delay_i)) begin
          dma_ack_o = 1'b1;
          wait_cnt  = 0;
        end else begin
          wait_cnt++;
        end
      end
    end
  end

  // one cycle done pulse for a channel.
  task automatic pulse_done(input int ch);
    @(posedge clk_i);
    #2;
    dma_done_o[ch] = 1'b1;
    @(posedge clk_i);
    #2;
    dma_done_o[ch] = 1'b0;
  endtask

  a_write_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dma_wr_i && dma_ack_o |-> exp_valid_i && dma_addr_i == exp_addr_i &&
      dma_wdata_i == exp_data_i)
  else begin
    err_count_o++;
    $display("ERROR %0s: expected valid %0b addr %h data %h, actual addr %h data %h",
      test_name_i, exp_valid_i, exp_addr_i, exp_data_i, dma_addr_i, dma_wdata_i);
  end

endmodule

// ==== dv/im2col_spc_tb.sv ====
/*
 * Testbench for the im2col peripheral controller. Stages descriptors through the
 * register port, queues the expected DMA writes and checks status and interrupt.
 */
module im2col_spc_tb import im2col_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NUM_CH     = 4;
  localparam int unsigned FIFO_DEPTH = 8;
  localparam int          TIMEOUT    = 2000;

  logic clk, rst_n, reg_we, reg_re, dma_wr, dma_ack, intr, exp_valid, ovf_sticky;
  logic [7:0]  reg_addr;
  logic [31:0] reg_wdata, reg_rdata, dma_addr, dma_wdata, exp_addr, exp_data, rd;
  logic [NUM_CH-1:0] dma_done, mask, busy, used;
  logic [1:0]  ack_delay, dt;
  logic [3:0]  ls;
  logic [7:0]  rx, tx;
  logic [15:0] lfsr_q;
  logic [8*16-1:0] test_name;
  logic [31:0] addr_q [$];
  logic [31:0] data_q [$];
  desc_t       held [FIFO_DEPTH];
  int          errors, dma_errors;

  im2col_spc_top #(.NUM_CH(NUM_CH), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (
    .clk_i(clk), .rst_ni(rst_n), .reg_we_i(reg_we), .reg_re_i(reg_re),
    .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
    .dma_wr_o(dma_wr), .dma_addr_o(dma_addr), .dma_wdata_o(dma_wdata),
    .dma_ack_i(dma_ack), .dma_done_i(dma_done), .intr_o(intr)
  );

  im2col_dma_model #(.NUM_CH(NUM_CH)) i_dma (
    .clk_i(clk), .rst_ni(rst_n), .dma_wr_i(dma_wr), .dma_addr_i(dma_addr),
    .dma_wdata_i(dma_wdata), .dma_ack_o(dma_ack), .dma_done_o(dma_done),
    .ack_delay_i(ack_delay), .exp_valid_i(exp_valid), .exp_addr_i(exp_addr),
    .exp_data_i(exp_data), .test_name_i(test_name), .err_count_o(dma_errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // galois lfsr stepped once per bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? 16'hb400 : 16'h0000);
    end
    return v;
  endfunction

  function automatic void show_head();
    exp_valid = (addr_q.size() != 0);
    exp_addr  = exp_valid ? addr_q[0] : '0;
    exp_data  = exp_valid ? data_q[0] : '0;
  endfunction

  // retire the write the model just acked and pick the next ack delay.
  always @(posedge clk) begin
    if (dma_wr && dma_ack && addr_q.size() != 0) begin
      void'(addr_q.pop_front());
      void'(data_q.pop_front());
      show_head();
      ack_delay <= 2'(rand_bits(2));
    end
  end

  task automatic give_up(input string what);
    $display("timeout: %0s", what);
    $display("sim failed");
    $finish;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk);
    #2;
    reg_we = 1'b0;
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    reg_re   = 1'b1;
    reg_addr = addr;
    #1;
    data = reg_rdata; // combinational read data.
    @(posedge clk);
    #2;
    reg_re = 1'b0;
  endtask

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
    assert (expected === actual) else begin
      errors++;
      $display("ERROR %0s: expected %h actual %h", test_name, expected, actual);
    end
  endtask

  function automatic desc_t rand_desc();
    desc_t d;
    d.pad_top    = 8'(rand_bits(8));
    d.pad_bottom = 8'(rand_bits(8));
    d.pad_left   = 8'(rand_bits(8));
    d.pad_right  = 8'(rand_bits(8));
    d.in_ptr     = rand_bits(32);
    d.out_ptr    = rand_bits(32);
    d.in_inc_d2  = 23'(rand_bits(23));
    d.size_d2    = 16'(rand_bits(16));
    d.size_d1    = 16'(rand_bits(16));
    return d;
  endfunction

  task automatic push_desc(input desc_t d);
    reg_write(REG_DESC_PAD, {d.pad_top, d.pad_bottom, d.pad_left, d.pad_right});
    reg_write(REG_DESC_IN_PTR, d.in_ptr);
    reg_write(REG_DESC_OUT_PTR, d.out_ptr);
    reg_write(REG_DESC_INC, {9'h0, d.in_inc_d2});
    reg_write(REG_DESC_SIZE, {d.size_d2, d.size_d1});
    reg_write(REG_DESC_PUSH, 32'h1);
  endtask

  task automatic expect_write(input int ch, input logic [7:0] off, input logic [31:0] data);
    addr_q.push_back(DMA_BASE + ch * DMA_CH_SIZE + 32'(off));
    data_q.push_back(data);
    show_head();
  endtask

  // lowest enabled channel that is not busy gets the next descriptor.
  task automatic expect_load(input desc_t d);
    int ch;
    int bpe;
    ch  = -1;
    bpe = (dt == 2'd0) ? 4 : (dt == 2'd1) ? 2 : 1; // bytes per element.
    for (int i = NUM_CH - 1; i >= 0; i--)
      if (mask[i] && !busy[i]) ch = i;
    if (ch < 0) give_up("no free channel predicted");
    busy[ch] = 1'b1;
    if (!used[ch]) begin
      expect_write(ch, DIM, 32'd1);
      expect_write(ch, SLOT, {16'h0, tx, rx});
      expect_write(ch, SRC_TYPE, {30'h0, dt});
      expect_write(ch, DST_TYPE, {30'h0, dt});
    end
    used[ch] = 1'b1;
    expect_write(ch, PAD_TOP, {24'h0, d.pad_top});
    expect_write(ch, PAD_BOTTOM, {24'h0, d.pad_bottom});
    expect_write(ch, PAD_LEFT, {24'h0, d.pad_left});
    expect_write(ch, PAD_RIGHT, {24'h0, d.pad_right});
    expect_write(ch, SRC_PTR, d.in_ptr);
    expect_write(ch, DST_PTR, d.out_ptr);
    expect_write(ch, SRC_INC_D1, ((32'd1 << ls) * bpe) % 64);
    expect_write(ch, SRC_INC_D2, ({9'h0, d.in_inc_d2} * bpe) % (1 << 23));
    expect_write(ch, DST_INC_D1, 32'(bpe));
    expect_write(ch, DST_INC_D2, 32'(bpe));
    expect_write(ch, SIZE_D2, {16'h0, d.size_d2});
    expect_write(ch, SIZE_D1, {16'h0, d.size_d1});
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (addr_q.size() != 0 || dma_wr) begin
      @(posedge clk);
      #2;
      if (++n > TIMEOUT) give_up("expected DMA writes never completed");
    end
  endtask

  task automatic free_channel(input int ch);
    busy[ch] = 1'b0;
    i_dma.pulse_done(ch);
  endtask

  task automatic start_run(input logic [NUM_CH-1:0] m, input logic int_en);
    reg_write(REG_START, 32'h1);
    busy       = '0;
    used       = '0;
    ovf_sticky = 1'b0;
    ls         = 4'(rand_bits(4));
    rx         = 8'(rand_bits(8));
    tx         = 8'(rand_bits(8));
    reg_write(REG_CFG, {10'h0, tx, rx, ls, dt});
    mask = m;
    reg_write(REG_CH_MASK, {28'h0, m});
    reg_write(REG_INT_EN, {31'h0, int_en});
  endtask

  task automatic finish_run(input logic want_intr);
    int n;
    reg_write(REG_END, 32'h1);
    n = 0;
    rd = '0;
    while (!rd[0] || (want_intr && !intr)) begin
      reg_read(REG_STATUS, rd);
      if (++n > TIMEOUT) give_up("done never returned the status to ready");
    end
    check_value({29'h0, 1'b1, ovf_sticky, 1'b1}, rd); // overflow stays until start.
    check_value({31'h0, want_intr}, {31'h0, intr});
  endtask

  initial begin
    desc_t d;
    rst_n      = 1'b0;
    reg_we     = 1'b0;
    reg_re     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    lfsr_q     = 16'd51;
    ack_delay  = 2'd0;
    errors     = 0;
    mask       = '0;
    busy       = '0;
    used       = '0;
    dt         = '0;
    ls         = '0;
    rx         = '0;
    tx         = '0;
    ovf_sticky = 1'b0;
    test_name  = "reset";
    show_head();
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    reg_read(REG_STATUS, rd);
    check_value(32'h5, rd); // ready, FIFO empty.
    check_value(32'h0, {30'h0, dma_wr, intr});

    test_name = "first_repeat";
    for (int t = 0; t < 3; t++) begin
      dt = 2'(t);
      start_run(4'b0001, 1'b0);
      for (int k = 0; k < 2; k++) begin
        d = rand_desc();
        expect_load(d);
        push_desc(d);
        wait_drained();
        free_channel(0);
      end
      finish_run(1'b0);
    end

    test_name = "mask_exhaust";
    dt = 2'd1;
    start_run(4'b1010, 1'b1);
    for (int k = 0; k < 2; k++) begin
      d = rand_desc();
      expect_load(d);
      push_desc(d);
    end
    wait_drained();
    d = rand_desc();
    push_desc(d);
    repeat (10) begin
      @(posedge clk);
      #2;
      check_value(32'h0, {31'h0, dma_wr}); // both enabled channels are busy.
    end
    busy[3] = 1'b0;
    expect_load(d);
    i_dma.pulse_done(3);
    wait_drained();
    free_channel(1);
    free_channel(3);

    test_name = "done_intr";
    finish_run(1'b1);
    reg_read(REG_IFR, rd);
    check_value(32'h1, rd);
    check_value(32'h0, {31'h0, intr});
    start_run(4'b0001, 1'b0);
    d = rand_desc();
    expect_load(d);
    push_desc(d);
    wait_drained();
    free_channel(0);
    finish_run(1'b0);

    test_name = "backpressure";
    dt = 2'd2;
    start_run(4'b0000, 1'b0);
    for (int k = 0; k < FIFO_DEPTH; k++) begin
      held[k] = rand_desc();
      push_desc(held[k]);
    end
    reg_read(REG_STATUS, rd);
    check_value(32'h0, rd);
    push_desc(rand_desc());
    ovf_sticky = 1'b1;
    reg_read(REG_STATUS, rd);
    check_value(32'h2, rd); // the dropped push sets overflow.
    mask = 4'b0001;
    for (int k = 0; k < FIFO_DEPTH; k++) begin
      expect_load(held[k]);
      if (k == 0) reg_write(REG_CH_MASK, 32'h1);
      wait_drained();
      free_channel(0);
    end
    repeat (10) begin
      @(posedge clk);
      #2;
      check_value(32'h0, {31'h0, dma_wr});
    end
    finish_run(1'b0);

    $display("errors: testbench %0d, dma model %0d", errors, dma_errors);
    if (errors + dma_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== im2col_spc_top.f ====
verilog/im2col_pkg.sv
verilog/im2col_spc_regs.sv
verilog/im2col_desc_fifo.sv
verilog/im2col_ch_tracker.sv
verilog/im2col_dma_loader.sv
verilog/im2col_spc_top.sv
dv/im2col_dma_model.sv
dv/im2col_spc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= im2col_spc_tb
RTL_TOP   ?= im2col_spc_top
FILELIST  ?= im2col_spc_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= sim failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
